// File: design/host_pkg.sv
package host_pkg;

	// ========================================
	// event word from the host link
	// ========================================

	// key view, scan code in the low byte
	typedef struct packed {
		logic [8:0] unused;
		logic       pressed;
		logic [7:0] code;
	} key_evt_t;

	// mouse view, two signed deltas
	typedef struct packed {
		logic signed [8:0] dx;
		logic signed [8:0] dy;
	} mouse_evt_t;

	typedef union packed {
		key_evt_t   key;
		mouse_evt_t mouse;
	} evt_word_u;

	// event kind, qualifies evt_word
	localparam logic EVT_KEY   = 1'b0;
	localparam logic EVT_MOUSE = 1'b1;

	// ps/2 set 2 scan codes
	localparam logic [7:0] KEY_UP     = 8'h75;
	localparam logic [7:0] KEY_DOWN   = 8'h72;
	localparam logic [7:0] KEY_LEFT   = 8'h6B;
	localparam logic [7:0] KEY_RIGHT  = 8'h74;
	localparam logic [7:0] KEY_COIN   = 8'h76;
	localparam logic [7:0] KEY_START1 = 8'h05;
	localparam logic [7:0] KEY_START2 = 8'h06;

	// joystick word layout
	localparam int unsigned JOY_W     = 6;
	localparam int unsigned JOY_RIGHT = 0;
	localparam int unsigned JOY_LEFT  = 1;
	localparam int unsigned JOY_DOWN  = 2;
	localparam int unsigned JOY_UP    = 3;

endpackage

// File: design/board_pkg.sv
package board_pkg;

	// ========================================
	// rom memory map
	// ========================================

	// byte address widths of the two regions
	localparam int unsigned CPU_ROM_AW = 12;
	localparam int unsigned SND_ROM_AW = 11;

	// storage is 16 bits wide, two bytes per word
	localparam int unsigned CPU_WORDS = 1 << (CPU_ROM_AW - 1);
	localparam int unsigned SND_WORDS = 1 << (SND_ROM_AW - 1);

	// download space, top bit picks the sound region
	localparam int unsigned DL_AW = 13;
	localparam logic [DL_AW-1:0] SND_BASE = {1'b1, {(DL_AW - 1){1'b0}}};

	// write port carries an offset into the larger region
	localparam int unsigned MEM_AW = CPU_ROM_AW;
	localparam logic REGION_CPU = 1'b0;
	localparam logic REGION_SND = 1'b1;

	// ========================================
	// host status word and buttons
	// ========================================

	localparam int unsigned STATUS_W  = 32;
	localparam int unsigned ST_RESET  = 0;
	localparam int unsigned ST_ROTATE = 2;

	localparam int unsigned BTN_W     = 2;
	localparam int unsigned BTN_RESET = 1;

	// trackball accumulators, top byte goes to the game
	localparam int unsigned TRACK_W     = 11;
	localparam int unsigned TRACK_OUT_W = 8;

endpackage

// File: design/boot_ctrl.sv
module boot_ctrl import board_pkg::*; (
	input  logic                clk_sys,
	input  logic                rst_n,
	// host download
	input  logic                dl_active,
	input  logic                dl_wr,
	input  logic [DL_AW-1:0]    dl_addr,
	input  logic [7:0]          dl_data,
	input  logic [STATUS_W-1:0] status,
	input  logic [BTN_W-1:0]    buttons,
	// write handshake towards rom_store
	output logic                mem_req,
	input  logic                mem_ack,
	output logic                mem_region,
	output logic [MEM_AW-1:0]   mem_addr,
	output logic [7:0]          mem_data,
	// game side
	output logic                game_reset,
	output logic                rom_loaded
);

	logic dl_wr_q;
	logic dl_active_q;
	logic wr_edge;
	logic wr_start;
	logic dl_done;

	assign wr_edge  = dl_active & dl_wr & ~dl_wr_q;
	// handshake idle only when both req and ack are low
	assign wr_start = wr_edge & ~mem_req & ~mem_ack;
	assign dl_done  = dl_active_q & ~dl_active;

	// ========================================
	// requester side of the handshake
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_wr_q     <= 1'b0;
			dl_active_q <= 1'b0;
			mem_req     <= 1'b0;
		end else begin
			dl_wr_q     <= dl_wr;
			dl_active_q <= dl_active;
			if (wr_start)
				mem_req <= 1'b1;
			else if (mem_req && mem_ack)
				mem_req <= 1'b0;
		end
	end

	// byte and offset are held until the next write
	always_ff @(posedge clk_sys) begin
		if (wr_start) begin
			mem_region <= dl_addr[DL_AW-1];
			mem_data   <= dl_data;
			// dropping the top bit takes off the sound base
			mem_addr   <= dl_addr[MEM_AW-1:0];
		end
	end

	// ========================================
	// boot sequence and game reset
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rom_loaded <= 1'b0;
			game_reset <= 1'b1;
		end else begin
			// sticky once the first download ends
			if (dl_done)
				rom_loaded <= 1'b1;
			game_reset <= ~rom_loaded | status[ST_RESET] | buttons[BTN_RESET];
		end
	end

	// req may only rise once the previous ack has been withdrawn
	a_req_after_ack: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(mem_req) |-> !mem_ack)
		else $error("mem_req rose while mem_ack still high");

	// no new write edge before the handshake has finished
	a_no_overrun: assert property (@(posedge clk_sys) disable iff (!rst_n)
		wr_edge |-> !(mem_req || mem_ack))
		else $error("download write arrived during a busy handshake");

endmodule

// File: design/rom_store.sv
module rom_store import board_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	// write port with four-phase handshake
	input  logic                  mem_req,
	output logic                  mem_ack,
	input  logic                  mem_region,
	input  logic [MEM_AW-1:0]     mem_addr,
	input  logic [7:0]            mem_data,
	// cpu rom read port
	input  logic [CPU_ROM_AW-1:0] cpu_rom_addr,
	output logic [7:0]            cpu_rom_do,
	// sound rom read port
	input  logic [SND_ROM_AW-1:0] snd_rom_addr,
	output logic [7:0]            snd_rom_do
);

	logic [15:0] cpu_mem [CPU_WORDS];
	logic [15:0] snd_mem [SND_WORDS];

	logic        wr_en;
	logic [15:0] cpu_word;
	logic [15:0] snd_word;
	logic        cpu_lane;
	logic        snd_lane;

	// a fresh request that is not yet acknowledged
	assign wr_en = mem_req & ~mem_ack;

	// ========================================
	// acknowledge side
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			mem_ack <= 1'b0;
		end else begin
			if (wr_en)
				mem_ack <= 1'b1;
			else if (!mem_req)
				mem_ack <= 1'b0;
		end
	end

	// address bit 0 picks the byte lane
	always_ff @(posedge clk_sys) begin
		if (wr_en && mem_region == REGION_CPU) begin
			if (mem_addr[0])
				cpu_mem[mem_addr[CPU_ROM_AW-1:1]][15:8] <= mem_data;
			else
				cpu_mem[mem_addr[CPU_ROM_AW-1:1]][7:0] <= mem_data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_en && mem_region == REGION_SND) begin
			if (mem_addr[0])
				snd_mem[mem_addr[SND_ROM_AW-1:1]][15:8] <= mem_data;
			else
				snd_mem[mem_addr[SND_ROM_AW-1:1]][7:0] <= mem_data;
		end
	end

	// ========================================
	// read ports
	// ========================================

	// word and lane registered together for one cycle of latency
	always_ff @(posedge clk_sys) begin
		cpu_word <= cpu_mem[cpu_rom_addr[CPU_ROM_AW-1:1]];
		cpu_lane <= cpu_rom_addr[0];
		snd_word <= snd_mem[snd_rom_addr[SND_ROM_AW-1:1]];
		snd_lane <= snd_rom_addr[0];
	end

	assign cpu_rom_do = cpu_lane ? cpu_word[15:8] : cpu_word[7:0];
	assign snd_rom_do = snd_lane ? snd_word[15:8] : snd_word[7:0];

	// ack rises only while the request is still held
	a_ack_needs_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(mem_ack) |-> mem_req)
		else $error("mem_ack rose without a pending mem_req");

endmodule

// File: design/player_controls.sv
module player_controls import host_pkg::*; (
	input  logic             clk_sys,
	input  logic             rst_n,
	// host events
	input  logic             evt_valid,
	input  logic             evt_kind,
	input  evt_word_u        evt_word,
	// joysticks and orientation
	input  logic [JOY_W-1:0] joy0,
	input  logic [JOY_W-1:0] joy1,
	input  logic             rotate,
	// player controls
	output logic             ctl_up,
	output logic             ctl_down,
	output logic             ctl_left,
	output logic             ctl_right,
	output logic             ctl_coin,
	output logic             ctl_start1,
	output logic             ctl_start2
);

	logic btn_up;
	logic btn_down;
	logic btn_left;
	logic btn_right;
	logic btn_coin;
	logic btn_start1;
	logic btn_start2;

	logic dir_up;
	logic dir_down;
	logic dir_left;
	logic dir_right;

	// ========================================
	// keyboard decode
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			btn_up     <= 1'b0;
			btn_down   <= 1'b0;
			btn_left   <= 1'b0;
			btn_right  <= 1'b0;
			btn_coin   <= 1'b0;
			btn_start1 <= 1'b0;
			btn_start2 <= 1'b0;
		end else if (evt_valid && evt_kind == EVT_KEY) begin
			case (evt_word.key.code)
				KEY_UP:     btn_up     <= evt_word.key.pressed;
				KEY_DOWN:   btn_down   <= evt_word.key.pressed;
				KEY_LEFT:   btn_left   <= evt_word.key.pressed;
				KEY_RIGHT:  btn_right  <= evt_word.key.pressed;
				KEY_COIN:   btn_coin   <= evt_word.key.pressed;
				KEY_START1: btn_start1 <= evt_word.key.pressed;
				KEY_START2: btn_start2 <= evt_word.key.pressed;
				// other keys are not mapped
				default: ;
			endcase
		end
	end

	// keys and both joysticks merged
	assign dir_up    = btn_up    | joy0[JOY_UP]    | joy1[JOY_UP];
	assign dir_down  = btn_down  | joy0[JOY_DOWN]  | joy1[JOY_DOWN];
	assign dir_left  = btn_left  | joy0[JOY_LEFT]  | joy1[JOY_LEFT];
	assign dir_right = btn_right | joy0[JOY_RIGHT] | joy1[JOY_RIGHT];

	// rotated cabinet, quarter turn
	assign ctl_up    = rotate ? dir_right : dir_up;
	assign ctl_down  = rotate ? dir_left  : dir_down;
	assign ctl_left  = rotate ? dir_up    : dir_left;
	assign ctl_right = rotate ? dir_down  : dir_right;

	assign ctl_coin   = btn_coin;
	assign ctl_start1 = btn_start1;
	assign ctl_start2 = btn_start2;

endmodule

// File: design/track_accum.sv
module track_accum import host_pkg::*, board_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   evt_valid,
	input  logic                   evt_kind,
	input  evt_word_u              evt_word,
	input  logic                   rotate,
	output logic [TRACK_OUT_W-1:0] track_x,
	output logic [TRACK_OUT_W-1:0] track_y
);

	logic signed [TRACK_W-1:0] x_pos;
	logic signed [TRACK_W-1:0] y_pos;
	logic signed [TRACK_W-1:0] dx_ext;
	logic signed [TRACK_W-1:0] dy_ext;

	// sign extend the 9 bit deltas
	assign dx_ext = {{(TRACK_W - 9){evt_word.mouse.dx[8]}}, evt_word.mouse.dx};
	assign dy_ext = {{(TRACK_W - 9){evt_word.mouse.dy[8]}}, evt_word.mouse.dy};

	// free running, wraps on overflow
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			x_pos <= '0;
			y_pos <= '0;
		end else if (evt_valid && evt_kind == EVT_MOUSE) begin
			if (rotate) begin
				x_pos <= x_pos - dy_ext;
				y_pos <= y_pos + dx_ext;
			end else begin
				x_pos <= x_pos + dx_ext;
				y_pos <= y_pos + dy_ext;
			end
		end
	end

	// low bits act as sub-count
	assign track_x = x_pos[TRACK_W-1 -: TRACK_OUT_W];
	assign track_y = y_pos[TRACK_W-1 -: TRACK_OUT_W];

endmodule

// File: design/arcade_glue_top.sv
module arcade_glue_top import host_pkg::*, board_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	// host download
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  logic [DL_AW-1:0]       dl_addr,
	input  logic [7:0]             dl_data,
	// host status and events
	input  logic [STATUS_W-1:0]    status,
	input  logic [BTN_W-1:0]       buttons,
	input  logic                   evt_valid,
	input  logic                   evt_kind,
	input  evt_word_u              evt_word,
	input  logic [JOY_W-1:0]       joy0,
	input  logic [JOY_W-1:0]       joy1,
	// game core side
	output logic                   game_reset,
	output logic                   rom_loaded,
	input  logic [CPU_ROM_AW-1:0]  cpu_rom_addr,
	output logic [7:0]             cpu_rom_do,
	input  logic [SND_ROM_AW-1:0]  snd_rom_addr,
	output logic [7:0]             snd_rom_do,
	output logic                   ctl_up,
	output logic                   ctl_down,
	output logic                   ctl_left,
	output logic                   ctl_right,
	output logic                   ctl_coin,
	output logic                   ctl_start1,
	output logic                   ctl_start2,
	output logic [TRACK_OUT_W-1:0] track_x,
	output logic [TRACK_OUT_W-1:0] track_y
);

	logic              mem_req;
	logic              mem_ack;
	logic              mem_region;
	logic [MEM_AW-1:0] mem_addr;
	logic [7:0]        mem_data;
	logic              rotate;

	// cabinet orientation from the host menu
	assign rotate = status[ST_ROTATE];

	// ========================================
	// download and boot
	// ========================================

	boot_ctrl u_boot_ctrl (
		.clk_sys, .rst_n,
		.dl_active, .dl_wr, .dl_addr, .dl_data,
		.status, .buttons,
		.mem_req, .mem_ack, .mem_region, .mem_addr, .mem_data,
		.game_reset, .rom_loaded
	);

	rom_store u_rom_store (
		.clk_sys, .rst_n,
		.mem_req, .mem_ack, .mem_region, .mem_addr, .mem_data,
		.cpu_rom_addr, .cpu_rom_do,
		.snd_rom_addr, .snd_rom_do
	);

	// ========================================
	// player inputs
	// ========================================

	player_controls u_player_controls (
		.clk_sys, .rst_n,
		.evt_valid, .evt_kind, .evt_word,
		.joy0, .joy1, .rotate,
		.ctl_up, .ctl_down, .ctl_left, .ctl_right,
		.ctl_coin, .ctl_start1, .ctl_start2
	);

	track_accum u_track_accum (
		.clk_sys, .rst_n,
		.evt_valid, .evt_kind, .evt_word, .rotate,
		.track_x, .track_y
	);

endmodule

// File: verif/tb_arcade_glue.sv
module tb_arcade_glue import host_pkg::*, board_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_DL    = 200;
	localparam int N_KEY   = 250;
	localparam int N_MOUSE = 250;
	localparam int N_EVT   = N_KEY + N_MOUSE;
	localparam int CYCLE_LIMIT = N_DL * 8 + N_EVT * 4 + 200;
	localparam logic [31:0] SEED = 32'ha681_b636;

	// order gives the button slot, up is slot 6 down to start2 at slot 0
	localparam logic [7:0] KNOWN_CODES [7] = '{
		KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT, KEY_COIN, KEY_START1, KEY_START2
	};

	logic                   clk_sys;
	logic                   rst_n;
	logic                   dl_active;
	logic                   dl_wr;
	logic [DL_AW-1:0]       dl_addr;
	logic [7:0]             dl_data;
	logic [STATUS_W-1:0]    status;
	logic [BTN_W-1:0]       buttons;
	logic                   evt_valid;
	logic                   evt_kind;
	evt_word_u              evt_word;
	logic [JOY_W-1:0]       joy0;
	logic [JOY_W-1:0]       joy1;
	logic                   game_reset;
	logic                   rom_loaded;
	logic [CPU_ROM_AW-1:0]  cpu_rom_addr;
	logic [7:0]             cpu_rom_do;
	logic [SND_ROM_AW-1:0]  snd_rom_addr;
	logic [7:0]             snd_rom_do;
	logic                   ctl_up;
	logic                   ctl_down;
	logic                   ctl_left;
	logic                   ctl_right;
	logic                   ctl_coin;
	logic                   ctl_start1;
	logic                   ctl_start2;
	logic [TRACK_OUT_W-1:0] track_x;
	logic [TRACK_OUT_W-1:0] track_y;

	// ========================================
	// reference model state
	// ========================================

	logic [7:0]            cpu_model [1 << CPU_ROM_AW];
	logic [7:0]            snd_model [1 << SND_ROM_AW];
	bit                    cpu_seen [1 << CPU_ROM_AW];
	bit                    snd_seen [1 << SND_ROM_AW];
	logic [CPU_ROM_AW-1:0] cpu_addrs [$];
	logic [SND_ROM_AW-1:0] snd_addrs [$];
	logic [6:0]            kb_model;
	logic signed [TRACK_W-1:0] mx;
	logic signed [TRACK_W-1:0] my;

	int err_rom   = 0;
	int err_track = 0;
	int err_ctl   = 0;
	int err_flag  = 0;
	int err_other = 0;
	int cycles    = 0;
	logic [31:0] seed_ret;

	arcade_glue_top i_dut (.*);

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	// watchdog
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ========================================
	// compare tasks
	// ========================================

	task automatic check_rom_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("error at %t: %s is %h, expected %h", $time, name, got, exp);
			err_rom++;
		end
	endtask

	task automatic compare_track(input string name, input logic [TRACK_OUT_W-1:0] got,
			input logic [TRACK_OUT_W-1:0] exp);
		if (got !== exp) begin
			$display("error at %t: %s is %h, expected %h", $time, name, got, exp);
			err_track++;
		end
	endtask

	task automatic verify_controls(input string name, input logic [6:0] got, input logic [6:0] exp);
		if (got !== exp) begin
			$display("error at %t: %s is %b, expected %b", $time, name, got, exp);
			err_ctl++;
		end
	endtask

	task automatic expect_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error at %t: %s is %b, expected %b", $time, name, got, exp);
			err_flag++;
		end
	endtask

	// ========================================
	// model helpers
	// ========================================

	function automatic int key_slot(input logic [7:0] code);
		for (int k = 0; k < 7; k++) begin
			if (KNOWN_CODES[k] == code)
				return 6 - k;
		end
		return -1;
	endfunction

	function automatic int sign_extend9(input logic [8:0] v);
		return int'({{23{v[8]}}, v});
	endfunction

	// {up, down, left, right, coin, start1, start2}
	function automatic logic [6:0] model_controls(input logic [6:0] kb, input logic [JOY_W-1:0] j0,
			input logic [JOY_W-1:0] j1, input logic rot);
		logic up;
		logic dn;
		logic lf;
		logic rt;
		up = kb[6] | j0[JOY_UP] | j1[JOY_UP];
		dn = kb[5] | j0[JOY_DOWN] | j1[JOY_DOWN];
		lf = kb[4] | j0[JOY_LEFT] | j1[JOY_LEFT];
		rt = kb[3] | j0[JOY_RIGHT] | j1[JOY_RIGHT];
		// quarter turn, up takes right, down takes left, left takes up, right takes down
		if (rot)
			return {rt, lf, up, dn, kb[2:0]};
		return {up, dn, lf, rt, kb[2:0]};
	endfunction

	task automatic sample_player_side();
		verify_controls("ctl {up,down,left,right,coin,start1,start2}",
			{ctl_up, ctl_down, ctl_left, ctl_right, ctl_coin, ctl_start1, ctl_start2},
			model_controls(kb_model, joy0, joy1, status[ST_ROTATE]));
		compare_track("track_x", track_x, mx[TRACK_W-1 -: TRACK_OUT_W]);
		compare_track("track_y", track_y, my[TRACK_W-1 -: TRACK_OUT_W]);
	endtask

	// ========================================
	// stimulus
	// ========================================

	// one host write, then the rest of the 8 cycle spacing
	task automatic download_byte(input logic region, input logic [CPU_ROM_AW-1:0] off,
			input logic [7:0] data);
		@(negedge clk_sys);
		dl_wr   = 1'b1;
		dl_data = data;
		if (region)
			dl_addr = SND_BASE + {1'b0, off};
		else
			dl_addr = {1'b0, off};
		@(negedge clk_sys);
		dl_wr = 1'b0;
		repeat (6) @(negedge clk_sys);
		if (region) begin
			if (!snd_seen[off[SND_ROM_AW-1:0]]) begin
				snd_seen[off[SND_ROM_AW-1:0]] = 1'b1;
				snd_addrs.push_back(off[SND_ROM_AW-1:0]);
			end
			snd_model[off[SND_ROM_AW-1:0]] = data;
		end else begin
			if (!cpu_seen[off]) begin
				cpu_seen[off] = 1'b1;
				cpu_addrs.push_back(off);
			end
			cpu_model[off] = data;
		end
		expect_flag("game_reset", game_reset, 1'b1);
	endtask

	task automatic load_rom();
		logic [31:0]           r;
		logic                  region;
		logic [CPU_ROM_AW-1:0] off;
		logic [CPU_ROM_AW-1:0] last_off [2];
		last_off[0] = '0;
		last_off[1] = '0;
		@(negedge clk_sys);
		dl_active = 1'b1;
		for (int i = 0; i < N_DL; i++) begin
			r = $urandom;
			region = r[0];
			// now and then fill the other lane of the previous word
			if (i > 1 && r[3:2] == 2'b00)
				off = last_off[region] ^ 12'd1;
			else if (region)
				off = {1'b0, r[30:20]};
			else
				off = r[31:20];
			last_off[region] = off;
			download_byte(region, off, r[11:4]);
		end
		@(negedge clk_sys);
		dl_active = 1'b0;
		@(negedge clk_sys);
		expect_flag("rom_loaded", rom_loaded, 1'b1);
		expect_flag("game_reset", game_reset, 1'b1);
		@(negedge clk_sys);
		expect_flag("game_reset", game_reset, 1'b0);
	endtask

	task automatic read_back_rom();
		int                    n;
		logic [7:0]            exp_cpu;
		logic [7:0]            exp_snd;
		logic [CPU_ROM_AW-1:0] ca;
		logic [SND_ROM_AW-1:0] sa;
		if (cpu_addrs.size() == 0 || snd_addrs.size() == 0) begin
			$display("the download left one ROM region without any written byte");
			err_other++;
			return;
		end
		n = (cpu_addrs.size() > snd_addrs.size()) ? cpu_addrs.size() : snd_addrs.size();
		for (int i = 0; i <= n; i++) begin
			@(negedge clk_sys);
			if (i > 0) begin
				check_rom_byte($sformatf("cpu_rom_do[%h]", ca), cpu_rom_do, exp_cpu);
				check_rom_byte($sformatf("snd_rom_do[%h]", sa), snd_rom_do, exp_snd);
			end
			if (i < n) begin
				ca = cpu_addrs[i % cpu_addrs.size()];
				sa = snd_addrs[i % snd_addrs.size()];
				cpu_rom_addr = ca;
				snd_rom_addr = sa;
				exp_cpu = cpu_model[ca];
				exp_snd = snd_model[sa];
			end
		end
	endtask

	task automatic exercise_reset_requests();
		@(negedge clk_sys);
		status[ST_RESET] = 1'b1;
		@(negedge clk_sys);
		expect_flag("game_reset", game_reset, 1'b1);
		status[ST_RESET] = 1'b0;
		@(negedge clk_sys);
		expect_flag("game_reset", game_reset, 1'b0);
		buttons[BTN_RESET] = 1'b1;
		@(negedge clk_sys);
		expect_flag("game_reset", game_reset, 1'b1);
		buttons[BTN_RESET] = 1'b0;
		@(negedge clk_sys);
		expect_flag("game_reset", game_reset, 1'b0);
	endtask

	// strobe for one cycle, outputs settle by the next falling edge
	task automatic pulse_event(input logic kind, input evt_word_u w, input logic [JOY_W-1:0] j0,
			input logic [JOY_W-1:0] j1, input logic rot);
		@(negedge clk_sys);
		evt_valid         = 1'b1;
		evt_kind          = kind;
		evt_word          = w;
		joy0              = j0;
		joy1              = j1;
		status[ST_ROTATE] = rot;
		@(negedge clk_sys);
		evt_valid = 1'b0;
	endtask

	task automatic drive_key_events();
		logic [31:0] r;
		logic [31:0] r2;
		evt_word_u   w;
		int          pick;
		int          slot;
		for (int i = 0; i < N_KEY; i++) begin
			r  = $urandom;
			r2 = $urandom;
			w.key.unused  = r[8:0];
			w.key.pressed = r[9];
			pick = int'(r[14:12]);
			// pick 7 gives a random byte, mostly unmapped
			w.key.code = (pick < 7) ? KNOWN_CODES[pick] : r[23:16];
			pulse_event(EVT_KEY, w, r2[13] ? r2[5:0] : '0, r2[14] ? r2[11:6] : '0, r2[12]);
			slot = key_slot(w.key.code);
			if (slot >= 0)
				kb_model[slot] = w.key.pressed;
			sample_player_side();
		end
	endtask

	task automatic drive_mouse_events();
		logic [31:0] r;
		evt_word_u   w;
		logic        rot;
		int          dxi;
		int          dyi;
		int          nx;
		int          ny;
		for (int i = 0; i < N_MOUSE; i++) begin
			r = $urandom;
			// a run of full-scale moves forces both accumulators to wrap
			if (i < 16) begin
				w.mouse.dx = 9'h0FF;
				w.mouse.dy = 9'h100;
			end else begin
				w.mouse.dx = r[8:0];
				w.mouse.dy = r[17:9];
			end
			rot = r[18];
			pulse_event(EVT_MOUSE, w, joy0, joy1, rot);
			dxi = sign_extend9(w.mouse.dx);
			dyi = sign_extend9(w.mouse.dy);
			if (rot) begin
				nx = int'(mx) - dyi;
				ny = int'(my) + dxi;
			end else begin
				nx = int'(mx) + dxi;
				ny = int'(my) + dyi;
			end
			mx = nx[TRACK_W-1:0];
			my = ny[TRACK_W-1:0];
			sample_player_side();
		end
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin
		seed_ret = $urandom(SEED);
		$timeformat(-9, 0, " ns", 0);
		rst_n        = 1'b0;
		dl_active    = 1'b0;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		status       = '0;
		buttons      = '0;
		evt_valid    = 1'b0;
		evt_kind     = EVT_KEY;
		evt_word     = '0;
		joy0         = '0;
		joy1         = '0;
		cpu_rom_addr = '0;
		snd_rom_addr = '0;
		kb_model     = '0;
		mx           = '0;
		my           = '0;

		repeat (4) @(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);
		expect_flag("game_reset", game_reset, 1'b1);
		expect_flag("rom_loaded", rom_loaded, 1'b0);
		sample_player_side();

		load_rom();
		read_back_rom();
		exercise_reset_requests();
		drive_key_events();
		drive_mouse_events();

		@(negedge clk_sys);
		$display("summary: rom %0d, track %0d, controls %0d, flags %0d, other %0d errors",
			err_rom, err_track, err_ctl, err_flag, err_other);
		if (err_rom + err_track + err_ctl + err_flag + err_other == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: build.f
design/host_pkg.sv
design/board_pkg.sv
design/boot_ctrl.sv
design/rom_store.sv
design/player_controls.sv
design/track_accum.sv
design/arcade_glue_top.sv
verif/tb_arcade_glue.sv

// File: Makefile
SIM  := obj_dir/Vtb_arcade_glue
SRCS := $(wildcard design/*.sv verif/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): build.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_arcade_glue -Mdir obj_dir -f build.f

# pass only when the simulation prints the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
